// ==== fifo_buf_defines.svh ====
`ifndef FIFO_BUF_DEFINES_SVH
`define FIFO_BUF_DEFINES_SVH

//////////////////////////////////////////////////
// FIFO geometry
//////////////////////////////////////////////////

// Command FIFO address bits for 8 descriptors
`define FB_CMD_AW 3

// Data FIFO address bits for 16 words
`define FB_DATA_AW 4

// Almost full and almost empty distance in entries
`define FB_ALMOST_N 2

// Register port
`define FB_APB_AW 8

`endif

// ==== fifo_buf_pkg.sv ====
`include "fifo_buf_defines.svh"

package fifo_buf_pkg;

	// DMA descriptor carried by the command FIFO
	typedef struct packed {
		logic [31:0] addr;
		logic [15:0] len;
		logic [7:0]  tag;
		logic [3:0]  opcode;
	} cmd_desc_t;

	typedef logic [31:0] data_word_t;

	// Registered status of one FIFO
	typedef struct packed {
		logic       full;
		logic       empty;
		logic       almost_full;
		logic       almost_empty;
		logic [1:0] level;
	} fifo_flags_t;

	// APB master to slave
	typedef struct packed {
		logic                  psel;
		logic                  penable;
		logic                  pwrite;
		logic [`FB_APB_AW-1:0] paddr;
		logic [31:0]           pwdata;
	} apb_req_t;

	// APB slave to master
	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

	// Register map byte offsets
	localparam logic [`FB_APB_AW-1:0] REG_CTRL     = 'h00;
	localparam logic [`FB_APB_AW-1:0] REG_STATUS   = 'h04;
	localparam logic [`FB_APB_AW-1:0] REG_CMD_CNT  = 'h08;
	localparam logic [`FB_APB_AW-1:0] REG_DATA_CNT = 'h0C;
	localparam logic [`FB_APB_AW-1:0] REG_ERR      = 'h10;

endpackage

// ==== dp_ram.sv ====
`timescale 1ns/1ps

module dp_ram #(
	parameter type payload_t = logic [31:0],
	parameter int AW = 3
) (
	input  logic          clk,
	input  logic          we,
	input  logic [AW-1:0] waddr,
	input  payload_t      wdata,
	input  logic [AW-1:0] raddr,
	input  logic          re,
	output payload_t      rdata
);

	// Storage for 2^AW entries
	payload_t mem [0:(1<<AW)-1];

	// Write port
	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// Read port registered
	// rdata holds its value until the next read strobe
	always_ff @(posedge clk) begin
		if (re) begin
			rdata <= mem[raddr];
		end
	end

endmodule

// ==== sc_fifo.sv ====
`timescale 1ns/1ps

module sc_fifo #(
	parameter type payload_t = logic [31:0],
	parameter int AW = 3,
	parameter int ALMOST_N = 2
) (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      clr,
	input  logic                      push,
	input  payload_t                  din,
	input  logic                      pop,
	output payload_t                  dout,
	output fifo_buf_pkg::fifo_flags_t flags,
	output logic [AW:0]               count,
	output logic                      overflow,
	output logic                      underflow
);

	// Depth and the two thresholds at count width
	localparam logic [AW:0] DEPTH = {1'b1, {AW{1'b0}}};
	localparam logic [AW:0] AE_LIMIT = (AW+1)'(ALMOST_N);
	localparam logic [AW:0] AF_LIMIT = DEPTH - AE_LIMIT;

	// Flags after reset or clear
	localparam fifo_buf_pkg::fifo_flags_t FLAGS_RST = '{
		full:         1'b0,
		empty:        1'b1,
		almost_full:  1'b0,
		almost_empty: 1'b1,
		level:        2'd0
	};

	logic [AW-1:0] wp;
	logic [AW-1:0] rp;
	logic [AW-1:0] wp_pl1;
	logic [AW-1:0] rp_pl1;
	logic          gb;
	logic          push_ok;
	logic          pop_ok;
	logic [AW:0]   cnt_nxt;
	logic [AW+2:0] lvl_raw;
	fifo_buf_pkg::fifo_flags_t flags_nxt;

	//////////////////////////////////////////////////
	// Handshake
	//////////////////////////////////////////////////

	// Judged against this cycle's registered flags
	assign push_ok = push & ~flags.full;
	assign pop_ok  = pop & ~flags.empty;

	assign wp_pl1 = wp + AW'(1);
	assign rp_pl1 = rp + AW'(1);

	// Storage, read data lands one cycle after an accepted pop
	dp_ram #(
		.payload_t(payload_t),
		.AW(AW)
	) ram_inst (
		.clk(clk),
		.we(push_ok),
		.waddr(wp),
		.wdata(din),
		.raddr(rp),
		.re(pop_ok),
		.rdata(dout)
	);

	//////////////////////////////////////////////////
	// Pointers and guard bit
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst || clr) begin
			wp <= '0;
			rp <= '0;
		end else begin
			if (push_ok) begin
				wp <= wp_pl1;
			end
			if (pop_ok) begin
				rp <= rp_pl1;
			end
		end
	end

	// Guard bit tells full from empty when wp equals rp
	always_ff @(posedge clk) begin
		if (!rst || clr) begin
			gb <= 1'b0;
		end else if (push_ok && !pop_ok && (wp_pl1 == rp)) begin
			gb <= 1'b1;
		end else if (pop_ok && !push_ok) begin
			gb <= 1'b0;
		end
	end

	//////////////////////////////////////////////////
	// Occupancy and flags
	//////////////////////////////////////////////////

	// Simultaneous push and pop leave the count alone
	always_comb begin
		cnt_nxt = count;
		if (push_ok && !pop_ok) begin
			cnt_nxt = count + 1'b1;
		end else if (pop_ok && !push_ok) begin
			cnt_nxt = count - 1'b1;
		end
	end

	// Flags computed from the next count
	always_comb begin
		// Quarter of the depth per level step
		lvl_raw = {cnt_nxt, 2'b00} >> AW;
		flags_nxt.full         = (cnt_nxt == DEPTH);
		flags_nxt.empty        = (cnt_nxt == '0);
		flags_nxt.almost_full  = (cnt_nxt > AF_LIMIT);
		flags_nxt.almost_empty = (cnt_nxt < AE_LIMIT);
		// Saturate at 3 when completely full
		flags_nxt.level = (lvl_raw > (AW+3)'(3)) ? 2'd3 : lvl_raw[1:0];
	end

	always_ff @(posedge clk) begin
		if (!rst || clr) begin
			count <= '0;
			flags <= FLAGS_RST;
		end else begin
			count <= cnt_nxt;
			flags <= flags_nxt;
		end
	end

	// One cycle error pulses for dropped requests
	always_ff @(posedge clk) begin
		if (!rst) begin
			overflow  <= 1'b0;
			underflow <= 1'b0;
		end else begin
			overflow  <= push & flags.full;
			underflow <= pop & flags.empty;
		end
	end

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	// Count based flags agree with the pointer and guard bit view
	a_empty_ptr: assert property (@(posedge clk) disable iff (!rst)
		flags.empty == ((wp == rp) && !gb));
	a_full_ptr: assert property (@(posedge clk) disable iff (!rst)
		flags.full == ((wp == rp) && gb));

	// Counter stays within the depth and tracks the pointer distance
	a_cnt_max: assert property (@(posedge clk) disable iff (!rst)
		(count <= DEPTH) && (count[AW-1:0] == AW'(wp - rp)));

endmodule

// ==== fifo_apb_regs.sv ====
`timescale 1ns/1ps
`include "fifo_buf_defines.svh"

module fifo_apb_regs (
	input  logic                      clk,
	input  logic                      rst,
	input  fifo_buf_pkg::apb_req_t    apb_req,
	output fifo_buf_pkg::apb_rsp_t    apb_rsp,
	input  fifo_buf_pkg::fifo_flags_t cmd_flags,
	input  fifo_buf_pkg::fifo_flags_t data_flags,
	input  logic [`FB_CMD_AW:0]       cmd_count,
	input  logic [`FB_DATA_AW:0]      data_count,
	input  logic                      cmd_ovf,
	input  logic                      cmd_unf,
	input  logic                      data_ovf,
	input  logic                      data_unf,
	output logic                      clr_cmd,
	output logic                      clr_data
);

	logic       setup_q;
	logic       access;
	logic       hit_ctrl;
	logic       hit_status;
	logic       hit_cmd_cnt;
	logic       hit_data_cnt;
	logic       hit_err;
	logic       slv_err;
	logic       wr_en;
	logic [3:0] err_q;
	logic [3:0] err_clr;

	//////////////////////////////////////////////////
	// APB phase tracking and decode
	//////////////////////////////////////////////////

	// Remember a setup phase so the access phase can be recognised
	always_ff @(posedge clk) begin
		if (!rst) begin
			setup_q <= 1'b0;
		end else begin
			setup_q <= apb_req.psel & ~apb_req.penable;
		end
	end

	assign access = apb_req.psel & apb_req.penable & setup_q;

	assign hit_ctrl     = (apb_req.paddr == fifo_buf_pkg::REG_CTRL);
	assign hit_status   = (apb_req.paddr == fifo_buf_pkg::REG_STATUS);
	assign hit_cmd_cnt  = (apb_req.paddr == fifo_buf_pkg::REG_CMD_CNT);
	assign hit_data_cnt = (apb_req.paddr == fifo_buf_pkg::REG_DATA_CNT);
	assign hit_err      = (apb_req.paddr == fifo_buf_pkg::REG_ERR);

	// Unmapped offset or write to a read only register
	assign slv_err = access & (~(hit_ctrl | hit_status | hit_cmd_cnt | hit_data_cnt | hit_err)
		| (apb_req.pwrite & (hit_status | hit_cmd_cnt | hit_data_cnt)));

	// Erroring writes change nothing
	assign wr_en = access & apb_req.pwrite & ~slv_err;

	//////////////////////////////////////////////////
	// Control and sticky errors
	//////////////////////////////////////////////////

	// Self clearing bits become one cycle clear pulses
	always_ff @(posedge clk) begin
		if (!rst) begin
			clr_cmd  <= 1'b0;
			clr_data <= 1'b0;
		end else begin
			clr_cmd  <= wr_en & hit_ctrl & apb_req.pwdata[0];
			clr_data <= wr_en & hit_ctrl & apb_req.pwdata[1];
		end
	end

	// Write one to clear
	assign err_clr = (wr_en && hit_err) ? apb_req.pwdata[3:0] : 4'b0000;

	// A new event wins over a clear in the same cycle
	always_ff @(posedge clk) begin
		if (!rst) begin
			err_q <= 4'b0000;
		end else begin
			err_q <= (err_q & ~err_clr) | {data_unf, data_ovf, cmd_unf, cmd_ovf};
		end
	end

	//////////////////////////////////////////////////
	// Response
	//////////////////////////////////////////////////

	always_comb begin
		apb_rsp.prdata = '0;
		if (access && !apb_req.pwrite) begin
			if (hit_status) begin
				apb_rsp.prdata = {20'd0, data_flags, cmd_flags};
			end else if (hit_cmd_cnt) begin
				apb_rsp.prdata = 32'(cmd_count);
			end else if (hit_data_cnt) begin
				apb_rsp.prdata = 32'(data_count);
			end else if (hit_err) begin
				apb_rsp.prdata = {28'd0, err_q};
			end
		end
		// No wait states
		apb_rsp.pready  = access;
		apb_rsp.pslverr = slv_err;
	end

	// Every access phase must follow a setup phase
	a_pready: assert property (@(posedge clk) disable iff (!rst)
		(apb_req.psel && apb_req.penable) |-> apb_rsp.pready);

endmodule

// ==== fifo_buf_top.sv ====
`timescale 1ns/1ps
`include "fifo_buf_defines.svh"

module fifo_buf_top (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       push_cmd,
	input  fifo_buf_pkg::cmd_desc_t    cmd_in,
	input  logic                       pop_cmd,
	output fifo_buf_pkg::cmd_desc_t    cmd_out,
	output fifo_buf_pkg::fifo_flags_t  cmd_flags,
	input  logic                       push_data,
	input  fifo_buf_pkg::data_word_t   data_in,
	input  logic                       pop_data,
	output fifo_buf_pkg::data_word_t   data_out,
	output fifo_buf_pkg::fifo_flags_t  data_flags,
	input  fifo_buf_pkg::apb_req_t     apb_req,
	output fifo_buf_pkg::apb_rsp_t     apb_rsp
);

	// Clear pulses from software
	logic clr_cmd;
	logic clr_data;

	// Occupancy and error pulses back to the register block
	logic [`FB_CMD_AW:0]  cmd_count;
	logic [`FB_DATA_AW:0] data_count;
	logic                 cmd_ovf;
	logic                 cmd_unf;
	logic                 data_ovf;
	logic                 data_unf;

	//////////////////////////////////////////////////
	// Descriptor FIFO
	//////////////////////////////////////////////////

	sc_fifo #(
		.payload_t(fifo_buf_pkg::cmd_desc_t),
		.AW(`FB_CMD_AW),
		.ALMOST_N(`FB_ALMOST_N)
	) cmd_fifo (
		.clk(clk),
		.rst(rst),
		.clr(clr_cmd),
		.push(push_cmd),
		.din(cmd_in),
		.pop(pop_cmd),
		.dout(cmd_out),
		.flags(cmd_flags),
		.count(cmd_count),
		.overflow(cmd_ovf),
		.underflow(cmd_unf)
	);

	//////////////////////////////////////////////////
	// Data word FIFO
	//////////////////////////////////////////////////

	sc_fifo #(
		.payload_t(fifo_buf_pkg::data_word_t),
		.AW(`FB_DATA_AW),
		.ALMOST_N(`FB_ALMOST_N)
	) data_fifo (
		.clk(clk),
		.rst(rst),
		.clr(clr_data),
		.push(push_data),
		.din(data_in),
		.pop(pop_data),
		.dout(data_out),
		.flags(data_flags),
		.count(data_count),
		.overflow(data_ovf),
		.underflow(data_unf)
	);

	// Software view
	fifo_apb_regs regs_inst (
		.clk(clk),
		.rst(rst),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp),
		.cmd_flags(cmd_flags),
		.data_flags(data_flags),
		.cmd_count(cmd_count),
		.data_count(data_count),
		.cmd_ovf(cmd_ovf),
		.cmd_unf(cmd_unf),
		.data_ovf(data_ovf),
		.data_unf(data_unf),
		.clr_cmd(clr_cmd),
		.clr_data(clr_data)
	);

endmodule

// ==== tb_fifo_buf.sv ====
`timescale 1ns/1ps
`include "fifo_buf_defines.svh"

module tb_fifo_buf;

	localparam int CMD_DEPTH = 1 << `FB_CMD_AW;
	localparam int DATA_DEPTH = 1 << `FB_DATA_AW;
	localparam int RESET_CYCLES = 16;
	localparam int RAND_CYCLES = 2000;
	// Margin for directed fills, drains and about thirty APB accesses of two cycles each
	localparam int DIRECTED_CYCLES = 984;
	localparam int CYCLE_LIMIT = RESET_CYCLES + RAND_CYCLES + DIRECTED_CYCLES;

	localparam fifo_buf_pkg::fifo_flags_t FLAGS_RESET = '{
		full:         1'b0,
		empty:        1'b1,
		almost_full:  1'b0,
		almost_empty: 1'b1,
		level:        2'd0
	};

	logic                      clk;
	logic                      rst;
	logic                      push_cmd;
	fifo_buf_pkg::cmd_desc_t   cmd_in;
	logic                      pop_cmd;
	fifo_buf_pkg::cmd_desc_t   cmd_out;
	fifo_buf_pkg::fifo_flags_t cmd_flags;
	logic                      push_data;
	fifo_buf_pkg::data_word_t  data_in;
	logic                      pop_data;
	fifo_buf_pkg::data_word_t  data_out;
	fifo_buf_pkg::fifo_flags_t data_flags;
	fifo_buf_pkg::apb_req_t    apb_req;
	fifo_buf_pkg::apb_rsp_t    apb_rsp;

	int seed;
	int cycles;

	// Reference model of both FIFOs
	fifo_buf_pkg::cmd_desc_t  cmd_q[$];
	fifo_buf_pkg::data_word_t data_q[$];
	logic                     cmd_pend;
	logic                     data_pend;
	fifo_buf_pkg::cmd_desc_t  cmd_exp;
	fifo_buf_pkg::data_word_t data_exp;
	// Sticky bits as {data_unf, data_ovf, cmd_unf, cmd_ovf}
	logic [3:0]               err_exp;

	fifo_buf_top fifo_buf_top_inst (
		.clk(clk),
		.rst(rst),
		.push_cmd(push_cmd),
		.cmd_in(cmd_in),
		.pop_cmd(pop_cmd),
		.cmd_out(cmd_out),
		.cmd_flags(cmd_flags),
		.push_data(push_data),
		.data_in(data_in),
		.pop_data(pop_data),
		.data_out(data_out),
		.data_flags(data_flags),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Run length guard
	initial begin
		cycles = 0;
		forever begin
			@(posedge clk);
			cycles++;
			if (cycles >= CYCLE_LIMIT) begin
				$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
				$display("Test FAILED");
				$fatal(1, "Simulation stopped by the cycle limit");
			end
		end
	end

	//////////////////////////////////////////////////
	// Checking helpers
	//////////////////////////////////////////////////

	task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
		if (exp !== act) begin
			$display("error %s: expected %0h actual %0h", name, exp, act);
			$display("Test FAILED");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	// Flag rules for count c in a FIFO of the given depth
	function automatic fifo_buf_pkg::fifo_flags_t flags_for(input int c, input int depth);
		fifo_buf_pkg::fifo_flags_t f;
		int lvl;
		lvl = (c * 4) / depth;
		f.full         = (c == depth);
		f.empty        = (c == 0);
		f.almost_full  = (c > depth - `FB_ALMOST_N);
		f.almost_empty = (c < `FB_ALMOST_N);
		f.level        = (lvl > 3) ? 2'd3 : lvl[1:0];
		return f;
	endfunction

	function automatic logic [31:0] status_exp();
		return {20'd0, flags_for(data_q.size(), DATA_DEPTH), flags_for(cmd_q.size(), CMD_DEPTH)};
	endfunction

	function automatic fifo_buf_pkg::cmd_desc_t rand_cmd();
		logic [63:0] r;
		r = {$random(seed), $random(seed)};
		return r[59:0];
	endfunction

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	// Advance to the next falling edge and compare flags and popped data
	task automatic wait_check();
		@(negedge clk);
		check("cmd_flags", flags_for(cmd_q.size(), CMD_DEPTH), cmd_flags);
		check("data_flags", flags_for(data_q.size(), DATA_DEPTH), data_flags);
		if (cmd_pend) begin
			check("cmd_out", cmd_exp, cmd_out);
		end
		if (data_pend) begin
			check("data_out", data_exp, data_out);
		end
		cmd_pend = 1'b0;
		data_pend = 1'b0;
	endtask

	// Drive one cycle of client traffic with acceptance judged on the model's size now
	task automatic traffic_cycle(input logic pc, input fifo_buf_pkg::cmd_desc_t ci, input logic oc,
		input logic pd, input fifo_buf_pkg::data_word_t di, input logic od);
		logic c_full;
		logic c_empty;
		logic d_full;
		logic d_empty;
		c_full  = (cmd_q.size() == CMD_DEPTH);
		c_empty = (cmd_q.size() == 0);
		d_full  = (data_q.size() == DATA_DEPTH);
		d_empty = (data_q.size() == 0);
		push_cmd = pc;
		cmd_in = ci;
		pop_cmd = oc;
		push_data = pd;
		data_in = di;
		pop_data = od;
		if (oc && c_empty) begin
			err_exp[1] = 1'b1;
		end else if (oc) begin
			cmd_exp = cmd_q.pop_front();
			cmd_pend = 1'b1;
		end
		if (pc && c_full) begin
			err_exp[0] = 1'b1;
		end else if (pc) begin
			cmd_q.push_back(ci);
		end
		if (od && d_empty) begin
			err_exp[3] = 1'b1;
		end else if (od) begin
			data_exp = data_q.pop_front();
			data_pend = 1'b1;
		end
		if (pd && d_full) begin
			err_exp[2] = 1'b1;
		end else if (pd) begin
			data_q.push_back(di);
		end
		wait_check();
	endtask

	task automatic idle_cycle();
		traffic_cycle(1'b0, '0, 1'b0, 1'b0, '0, 1'b0);
	endtask

	// Zero wait APB transfer, sampled inside the access phase
	task automatic apb_access(input logic wr, input logic [`FB_APB_AW-1:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
		idle_cycle();
		apb_req.penable = 1'b1;
		#2;
		check("apb_pready", 1'b1, apb_rsp.pready);
		rdata = apb_rsp.prdata;
		err = apb_rsp.pslverr;
		wait_check();
		apb_req = '0;
	endtask

	task automatic apb_read(input string name, input logic [`FB_APB_AW-1:0] addr,
		input logic [31:0] exp);
		logic [31:0] v;
		logic e;
		apb_access(1'b0, addr, 32'd0, v, e);
		check({name, " pslverr"}, 1'b0, e);
		check(name, exp, v);
	endtask

	task automatic apb_write(input string name, input logic [`FB_APB_AW-1:0] addr,
		input logic [31:0] wdata);
		logic [31:0] v;
		logic e;
		apb_access(1'b1, addr, wdata, v, e);
		check({name, " pslverr"}, 1'b0, e);
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin
		logic [31:0] r;
		logic [31:0] rd_val;
		logic        rd_err;
		logic        fill;
		seed = 32'h424aa70a;
		rst = 1'b0;
		push_cmd = 1'b0;
		cmd_in = '0;
		pop_cmd = 1'b0;
		push_data = 1'b0;
		data_in = '0;
		pop_data = 1'b0;
		apb_req = '0;
		cmd_pend = 1'b0;
		data_pend = 1'b0;
		cmd_exp = '0;
		data_exp = '0;
		err_exp = 4'b0000;
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b1;

		// Reset state
		idle_cycle();
		check("reset cmd_flags", FLAGS_RESET, cmd_flags);
		check("reset data_flags", FLAGS_RESET, data_flags);
		apb_read("reset status", fifo_buf_pkg::REG_STATUS, status_exp());
		apb_read("reset cmd count", fifo_buf_pkg::REG_CMD_CNT, 32'd0);
		apb_read("reset data count", fifo_buf_pkg::REG_DATA_CNT, 32'd0);
		apb_read("reset err", fifo_buf_pkg::REG_ERR, 32'd0);

		// Random traffic, alternating fill heavy and drain heavy blocks
		for (int i = 0; i < RAND_CYCLES; i++) begin
			r = $random(seed);
			fill = (((i / 250) % 2) == 0);
			traffic_cycle(fill ? (r[1:0] != 2'd0) : (r[1:0] == 2'd0), rand_cmd(),
				fill ? (r[3:2] == 2'd0) : (r[3:2] != 2'd0),
				fill ? (r[5:4] != 2'd0) : (r[5:4] == 2'd0), $random(seed),
				fill ? (r[7:6] == 2'd0) : (r[7:6] != 2'd0));
		end
		apb_read("random err", fifo_buf_pkg::REG_ERR, {28'd0, err_exp});
		apb_write("err clear all", fifo_buf_pkg::REG_ERR, 32'hF);
		err_exp = 4'b0000;

		// Overflow and underflow
		while (cmd_q.size() > 0 || data_q.size() > 0) begin
			traffic_cycle(1'b0, '0, cmd_q.size() > 0, 1'b0, '0, data_q.size() > 0);
		end
		repeat (CMD_DEPTH + 1) traffic_cycle(1'b1, rand_cmd(), 1'b0, 1'b0, '0, 1'b0);
		traffic_cycle(1'b0, '0, 1'b0, 1'b0, '0, 1'b1);
		apb_read("err cmd ovf data unf", fifo_buf_pkg::REG_ERR, 32'h9);
		apb_write("err w1c 9", fifo_buf_pkg::REG_ERR, 32'h9);
		err_exp = 4'b0000;
		apb_read("err after w1c 9", fifo_buf_pkg::REG_ERR, 32'd0);
		repeat (CMD_DEPTH + 1) traffic_cycle(1'b0, '0, 1'b1, 1'b0, '0, 1'b0);
		repeat (DATA_DEPTH + 1) traffic_cycle(1'b0, '0, 1'b0, 1'b1, $random(seed), 1'b0);
		apb_read("err cmd unf data ovf", fifo_buf_pkg::REG_ERR, 32'h6);
		// Only the written one clears
		apb_write("err w1c 2", fifo_buf_pkg::REG_ERR, 32'h2);
		apb_read("err after w1c 2", fifo_buf_pkg::REG_ERR, 32'h4);
		apb_write("err w1c 4", fifo_buf_pkg::REG_ERR, 32'h4);
		err_exp = 4'b0000;
		apb_read("err after w1c 4", fifo_buf_pkg::REG_ERR, 32'd0);

		// Clear of each FIFO on its own
		repeat (5) traffic_cycle(1'b1, rand_cmd(), 1'b0, 1'b0, '0, 1'b0);
		apb_write("ctrl clr cmd", fifo_buf_pkg::REG_CTRL, 32'h1);
		cmd_q.delete();
		idle_cycle();
		check("clr cmd_flags", FLAGS_RESET, cmd_flags);
		apb_read("clr cmd count", fifo_buf_pkg::REG_CMD_CNT, 32'd0);
		apb_read("clr data untouched", fifo_buf_pkg::REG_DATA_CNT, data_q.size());
		repeat (3) traffic_cycle(1'b1, rand_cmd(), 1'b0, 1'b0, '0, 1'b0);
		apb_write("ctrl clr data", fifo_buf_pkg::REG_CTRL, 32'h2);
		data_q.delete();
		idle_cycle();
		check("clr data_flags", FLAGS_RESET, data_flags);
		apb_read("clr data count", fifo_buf_pkg::REG_DATA_CNT, 32'd0);
		apb_read("clr cmd untouched", fifo_buf_pkg::REG_CMD_CNT, 32'd3);

		// Slave errors leave every register as it was
		apb_access(1'b1, 8'h20, 32'h3, rd_val, rd_err);
		check("unmapped write pslverr", 1'b1, rd_err);
		apb_access(1'b0, 8'h40, 32'd0, rd_val, rd_err);
		check("unmapped read pslverr", 1'b1, rd_err);
		apb_access(1'b1, fifo_buf_pkg::REG_STATUS, 32'hFFF, rd_val, rd_err);
		check("status write pslverr", 1'b1, rd_err);
		apb_access(1'b1, fifo_buf_pkg::REG_CMD_CNT, 32'h1, rd_val, rd_err);
		check("count write pslverr", 1'b1, rd_err);
		idle_cycle();
		idle_cycle();
		apb_read("status after errors", fifo_buf_pkg::REG_STATUS, status_exp());
		apb_read("cmd count after errors", fifo_buf_pkg::REG_CMD_CNT, 32'd3);
		apb_read("err after errors", fifo_buf_pkg::REG_ERR, {28'd0, err_exp});

		$display("Test OK");
		$finish;
	end

endmodule

// ==== fifo_buf.f ====
+incdir+.
fifo_buf_pkg.sv
dp_ram.sv
sc_fifo.sv
fifo_apb_regs.sv
fifo_buf_top.sv
tb_fifo_buf.sv

// ==== Bender.yml ====
package:
  name: fifo_buf

sources:
  - include_dirs:
      - .
    files:
      - fifo_buf_pkg.sv
      - dp_ram.sv
      - sc_fifo.sv
      - fifo_apb_regs.sv
      - fifo_buf_top.sv
      - target: test
        files:
          - tb_fifo_buf.sv
